//--- dma_req.f
hw/dma_req_pkg.sv
hw/dma_req_if.sv
hw/req_intake.sv
hw/req_splitter.sv
hw/page_translate.sv
hw/cmd_issue.sv
hw/dma_req_top.sv
bench/tb_dma_req.sv

//--- run_sim.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing -Wno-fatal -f dma_req.f --top-module tb_dma_req \
    -o tb_dma_req > build.log 2>&1 \
    && ./obj_dir/tb_dma_req > sim.log 2>&1 \
    || { cat build.log sim.log 2>/dev/null; echo "build or simulation did not complete"; exit 1; }

cat sim.log
grep -q "RESULT: FAIL" sim.log && exit 1
grep -q "RESULT: PASS" sim.log || exit 1

//--- bench/tb_dma_req.sv
`timescale 1ns/10ps

module tb_dma_req;
    localparam int chunk_bytes = 256;
    localparam int tlb_entries = 8;
    localparam int num_tests   = 5;

    logic                  aclk;
    logic                  aresetn;
    logic                  host_cyc;
    logic                  host_stb;
    logic                  host_we;
    dma_req_pkg::wb_adr_t  host_adr;
    dma_req_pkg::wb_data_t host_dat_w;
    dma_req_pkg::wb_data_t host_dat_r;
    logic                  host_ack;
    logic                  cmd_cyc;
    logic                  cmd_stb;
    logic                  cmd_we;
    dma_req_pkg::paddr_t   cmd_adr;
    dma_req_pkg::wb_data_t cmd_dat;
    logic                  cmd_ack;

    // Testbench copy of the TLB
    logic [19:0] ref_tag [tlb_entries];
    logic [19:0] ref_ppn [tlb_entries];
    logic        ref_valid [tlb_entries];

    logic [31:0] exp_adr [$];
    logic [31:0] exp_dat [$];
    logic [31:0] obs_adr [$];
    logic [31:0] obs_dat [$];

    int errors;
    int checks;
    int tests_done;

    dma_req_top #(
        .chunk_bytes (chunk_bytes),
        .tlb_entries (tlb_entries)
    ) u_dut (
        .aclk       (aclk),
        .aresetn    (aresetn),
        .host_cyc   (host_cyc),
        .host_stb   (host_stb),
        .host_we    (host_we),
        .host_adr   (host_adr),
        .host_dat_w (host_dat_w),
        .host_dat_r (host_dat_r),
        .host_ack   (host_ack),
        .cmd_cyc    (cmd_cyc),
        .cmd_stb    (cmd_stb),
        .cmd_we     (cmd_we),
        .cmd_adr    (cmd_adr),
        .cmd_dat    (cmd_dat),
        .cmd_ack    (cmd_ack)
    );

    initial aclk = 1'b0;
    always #20 aclk = ~aclk;

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL %s: got %08h, expected %08h", name, got, exp);
        end
    endtask

    // One classic host cycle with ack sampled mid-cycle
    task automatic host_cycle(input logic we, input logic [5:0] adr, input logic [31:0] wdata,
                              output logic [31:0] rdata);
        @(posedge aclk);
        #2;
        host_cyc   = 1'b1;
        host_stb   = 1'b1;
        host_we    = we;
        host_adr   = adr;
        host_dat_w = wdata;
        @(negedge aclk);
        while (!host_ack) @(negedge aclk);
        rdata = host_dat_r;
        @(posedge aclk);
        #2;
        host_cyc = 1'b0;
        host_stb = 1'b0;
        host_we  = 1'b0;
    endtask

    task automatic host_write(input logic [5:0] adr, input logic [31:0] data);
        logic [31:0] unused;
        host_cycle(1'b1, adr, data, unused);
    endtask

    task automatic host_read(input logic [5:0] adr, output logic [31:0] data);
        host_cycle(1'b0, adr, 32'h0, data);
    endtask

    task automatic tlb_load(input int idx, input logic [19:0] vpn, input logic [19:0] ppn,
                            input logic valid);
        host_write(dma_req_pkg::reg_tlb_vpn, {12'h0, vpn});
        host_write(dma_req_pkg::tlb_base + 6'(idx), {valid, 11'h0, ppn});
        ref_tag[idx]   = vpn;
        ref_ppn[idx]   = ppn;
        ref_valid[idx] = valid;
    endtask

    // Expected commands for one descriptor against the current TLB copy
    function automatic void expect_request(input logic [31:0] vaddr, input logic [15:0] len,
                                           input logic [31:0] flags);
        logic [31:0] addr;
        logic [15:0] rem;
        logic [15:0] clen;
        logic        last;
        logic [19:0] vpn;
        int          idx;
        logic        hit;
        logic [31:0] word;
        addr = vaddr;
        rem  = len;
        last = 1'b0;
        while (!last) begin
            if (rem > 16'(chunk_bytes)) begin
                clen = 16'(chunk_bytes);
            end else begin
                clen = rem;
                last = 1'b1;
            end
            vpn  = addr[31:12];
            idx  = int'(vpn) % tlb_entries;
            hit  = ref_valid[idx] && (ref_tag[idx] == vpn);
            word = 32'h0;
            word[15:0]  = clen;
            word[19:16] = flags[7:4];
            word[20]    = last && flags[0];
            word[21]    = flags[1];
            word[22]    = flags[2];
            word[23]    = !hit;
            exp_adr.push_back(hit ? {ref_ppn[idx], addr[11:0]} : addr);
            exp_dat.push_back(word);
            rem  = rem - clen;
            addr = addr + 32'(chunk_bytes);
        end
    endfunction

    task automatic submit(input logic [31:0] vaddr, input logic [15:0] len,
                          input logic [31:0] flags);
        host_write(dma_req_pkg::reg_vaddr, vaddr);
        host_write(dma_req_pkg::reg_len, {16'h0, len});
        host_write(dma_req_pkg::reg_flags, flags);
        expect_request(vaddr, len, flags);
        host_write(dma_req_pkg::reg_doorbell, 32'h0);
    endtask

    // Lets stray commands show up before the next test
    task automatic wait_drain;
        while (exp_adr.size() != 0) @(posedge aclk);
        repeat (16) @(posedge aclk);
    endtask

    task automatic report_test(input string name, input int err_before);
        tests_done++;
        if (errors == err_before) begin
            $display("test %0d %s: ok", tests_done, name);
        end else begin
            $display("test %0d %s: %0d errors", tests_done, name, errors - err_before);
        end
    endtask

    task automatic run_random;
        logic [31:0] va;
        logic [15:0] ln;
        logic [31:0] fl;
        logic [31:0] rd;
        int          pick;
        int          i;
        for (i = 0; i < 6; i++) begin
            pick = $urandom_range(3, 0);
            case (pick)
                0: va[31:12] = 20'h00001;
                1: va[31:12] = 20'h00002;
                2: va[31:12] = 20'h80005;
                default: va[31:12] = 20'h00033;
            endcase
            va[11:0] = 12'($urandom_range(4095, 0));
            ln = 16'($urandom_range(1023, 0));
            fl = {24'h0, 4'($urandom_range(15, 0)), 1'b0, 3'($urandom_range(7, 0))};
            submit(va, ln, fl);
        end
        wait_drain();
        host_write(dma_req_pkg::reg_vaddr, 32'h1234_5678);
        host_write(dma_req_pkg::reg_len, 32'hffff_abcd);
        host_write(dma_req_pkg::reg_flags, 32'h0000_00a5);
        host_read(dma_req_pkg::reg_vaddr, rd);
        check("host_dat_r", rd, 32'h1234_5678);
        host_read(dma_req_pkg::reg_len, rd);
        check("host_dat_r", rd, 32'h0000_abcd);
        host_read(dma_req_pkg::reg_flags, rd);
        check("host_dat_r", rd, 32'h0000_00a5);
        host_read(6'd5, rd);
        check("host_dat_r", rd, 32'h0);
    endtask

    // Command port slave with random ack delay
    initial begin
        int delay;
        cmd_ack = 1'b0;
        forever begin
            @(negedge aclk);
            if (cmd_stb) begin
                check("cmd_cyc", 32'(cmd_cyc), 32'h1);
                check("cmd_we", 32'(cmd_we), 32'h1);
                obs_adr.push_back(cmd_adr);
                obs_dat.push_back(cmd_dat);
                delay = $urandom_range(5, 0);
                repeat (delay) @(posedge aclk);
                @(posedge aclk);
                #2;
                cmd_ack = 1'b1;
                @(posedge aclk);
                #2;
                cmd_ack = 1'b0;
            end
        end
    end

    initial begin
        logic [31:0] got_adr;
        logic [31:0] got_dat;
        forever begin
            @(posedge aclk);
            while (obs_adr.size() != 0) begin
                got_adr = obs_adr.pop_front();
                got_dat = obs_dat.pop_front();
                if (exp_adr.size() == 0) begin
                    errors++;
                    $display("unexpected command at address %08h with no request pending",
                             got_adr);
                end else begin
                    check("cmd_adr", got_adr, exp_adr.pop_front());
                    check("cmd_dat", got_dat, exp_dat.pop_front());
                end
            end
        end
    end

    initial begin
        repeat (num_tests * 2000) @(posedge aclk);
        $display("timeout: the run did not finish within %0d cycles", num_tests * 2000);
        $display("RESULT: FAIL");
        $finish;
    end

    initial begin
        int err0;
        int i;
        void'($urandom(32'h5223e108));
        errors     = 0;
        checks     = 0;
        tests_done = 0;
        aresetn    = 1'b0;
        host_cyc   = 1'b0;
        host_stb   = 1'b0;
        host_we    = 1'b0;
        host_adr   = '0;
        host_dat_w = '0;
        for (i = 0; i < tlb_entries; i++) begin
            ref_tag[i]   = '0;
            ref_ppn[i]   = '0;
            ref_valid[i] = 1'b0;
        end
        repeat (4) @(posedge aclk);
        #2;
        aresetn = 1'b1;

        err0 = errors;
        tlb_load(1, 20'h00001, 20'habcde, 1'b1);
        submit(32'h0000_1100, 16'd200, 32'h31);
        submit(32'h0000_1010, 16'd0, 32'h02);
        submit(32'h0000_1000, 16'd256, 32'h75);
        wait_drain();
        report_test("single chunk", err0);

        err0 = errors;
        submit(32'h0000_1200, 16'd808, 32'h55);
        submit(32'h0000_1f80, 16'd600, 32'h03);
        wait_drain();
        report_test("multi chunk", err0);

        err0 = errors;
        tlb_load(2, 20'h00002, 20'h12345, 1'b1);
        tlb_load(5, 20'h80005, 20'h00777, 1'b1);
        submit(32'h8000_5abc, 16'd100, 32'h01);
        submit(32'h0000_2010, 16'd512, 32'h24);
        wait_drain();
        // Later requests see the new mapping
        tlb_load(5, 20'h80005, 20'h00888, 1'b1);
        submit(32'h8000_5abc, 16'd100, 32'h01);
        wait_drain();
        report_test("tlb mapping", err0);

        err0 = errors;
        tlb_load(4, 20'h00004, 20'h00444, 1'b0);
        submit(32'h0000_9040, 16'd300, 32'h01);
        submit(32'h0000_3000, 16'd64, 32'h00);
        submit(32'h0000_4000, 16'd64, 32'h06);
        wait_drain();
        report_test("tlb miss", err0);

        err0 = errors;
        run_random();
        report_test("random back to back", err0);

        $display("tests %0d, checks %0d, errors %0d", tests_done, checks, errors);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

//--- hw/dma_req_top.sv
`timescale 1ns/10ps

module dma_req_top #(
    parameter int chunk_bytes = 1024,
    parameter int tlb_entries = 8
) (
    input  logic                  aclk,
    input  logic                  aresetn,
    input  logic                  host_cyc,
    input  logic                  host_stb,
    input  logic                  host_we,
    input  dma_req_pkg::wb_adr_t  host_adr,
    input  dma_req_pkg::wb_data_t host_dat_w,
    output dma_req_pkg::wb_data_t host_dat_r,
    output logic                  host_ack,
    output logic                  cmd_cyc,
    output logic                  cmd_stb,
    output logic                  cmd_we,
    output dma_req_pkg::paddr_t   cmd_adr,
    output dma_req_pkg::wb_data_t cmd_dat,
    input  logic                  cmd_ack
);
    req_stage_if #(.addr_t(dma_req_pkg::vaddr_t)) desc_if ();
    req_stage_if #(.addr_t(dma_req_pkg::vaddr_t)) chunk_if ();
    req_stage_if #(.addr_t(dma_req_pkg::paddr_t)) phys_if ();
    tlb_wr_if #(.tlb_entries(tlb_entries)) tlb_wr ();

    req_intake #(
        .tlb_entries (tlb_entries)
    ) u_intake (
        .aclk       (aclk),
        .aresetn    (aresetn),
        .host_cyc   (host_cyc),
        .host_stb   (host_stb),
        .host_we    (host_we),
        .host_adr   (host_adr),
        .host_dat_w (host_dat_w),
        .host_dat_r (host_dat_r),
        .host_ack   (host_ack),
        .req_out    (desc_if),
        .tlb_wr     (tlb_wr)
    );

    req_splitter #(
        .chunk_bytes (chunk_bytes)
    ) u_splitter (
        .aclk      (aclk),
        .aresetn   (aresetn),
        .req_in    (desc_if),
        .chunk_out (chunk_if)
    );

    page_translate #(
        .tlb_entries (tlb_entries)
    ) u_translate (
        .aclk     (aclk),
        .aresetn  (aresetn),
        .tlb_wr   (tlb_wr),
        .virt_in  (chunk_if),
        .phys_out (phys_if)
    );

    cmd_issue u_issue (
        .aclk     (aclk),
        .aresetn  (aresetn),
        .cmd_ack  (cmd_ack),
        .chunk_in (phys_if),
        .cmd_cyc  (cmd_cyc),
        .cmd_stb  (cmd_stb),
        .cmd_we   (cmd_we),
        .cmd_adr  (cmd_adr),
        .cmd_dat  (cmd_dat)
    );

endmodule

//--- hw/cmd_issue.sv
`timescale 1ns/10ps

module cmd_issue (
    input  logic                  aclk,
    input  logic                  aresetn,
    input  logic                  cmd_ack,
    req_stage_if.dst              chunk_in,
    output logic                  cmd_cyc,
    output logic                  cmd_stb,
    output logic                  cmd_we,
    output dma_req_pkg::paddr_t   cmd_adr,
    output dma_req_pkg::wb_data_t cmd_dat
);
    logic                  active_q;
    logic                  take;
    dma_req_pkg::wb_data_t word;

    // One write in flight, next chunk only after ack
    assign chunk_in.ready = !active_q;
    assign take           = chunk_in.valid && !active_q;

    always_comb begin
        word = '0;
        word[dma_req_pkg::cmd_len_lsb +: dma_req_pkg::len_bits]   = chunk_in.len;
        word[dma_req_pkg::cmd_dest_lsb +: dma_req_pkg::dest_bits] = chunk_in.dest;
        word[dma_req_pkg::cmd_ctl_bit]    = chunk_in.ctl;
        word[dma_req_pkg::cmd_sync_bit]   = chunk_in.sync;
        word[dma_req_pkg::cmd_stream_bit] = chunk_in.stream;
        word[dma_req_pkg::cmd_fault_bit]  = chunk_in.fault;
    end

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            active_q <= 1'b0;
        end else if (take) begin
            active_q <= 1'b1;
        end else if (cmd_ack) begin
            active_q <= 1'b0;
        end
    end

    always_ff @(posedge aclk) begin
        if (take) begin
            cmd_adr <= chunk_in.addr;
            cmd_dat <= word;
        end
    end

    // Classic single write, all strobes held until ack
    assign cmd_cyc = active_q;
    assign cmd_stb = active_q;
    assign cmd_we  = active_q;

endmodule

//--- hw/page_translate.sv
`timescale 1ns/10ps

module page_translate #(
    parameter int tlb_entries = 8
) (
    input  logic      aclk,
    input  logic      aresetn,
    tlb_wr_if.dst     tlb_wr,
    req_stage_if.dst  virt_in,
    req_stage_if.src  phys_out
);
    localparam int idx_bits = $clog2(tlb_entries);

    dma_req_pkg::vpn_t   tag_q [tlb_entries];
    dma_req_pkg::ppn_t   ppn_q [tlb_entries];
    logic [tlb_entries-1:0] entry_valid_q;

    dma_req_pkg::vpn_t   in_vpn;
    logic [idx_bits-1:0] in_idx;
    logic                hit;
    logic                take;

    logic                out_valid_q;
    dma_req_pkg::paddr_t addr_q;
    dma_req_pkg::len_t   len_q;
    logic                ctl_q;
    logic                sync_q;
    logic                stream_q;
    dma_req_pkg::dest_t  dest_q;
    logic                fault_q;

    // Direct mapped, index from the low vpn bits, tag is the full vpn
    assign in_vpn = virt_in.addr[dma_req_pkg::page_off_bits +: dma_req_pkg::pn_bits];
    assign in_idx = in_vpn[idx_bits-1:0];
    assign hit    = entry_valid_q[in_idx] && (tag_q[in_idx] == in_vpn);

    assign virt_in.ready = !out_valid_q || phys_out.ready;
    assign take          = virt_in.valid && virt_in.ready;

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            entry_valid_q <= '0;
        end else if (tlb_wr.wr_en) begin
            entry_valid_q[tlb_wr.wr_index] <= tlb_wr.wr_valid;
        end
    end

    always_ff @(posedge aclk) begin
        if (tlb_wr.wr_en) begin
            tag_q[tlb_wr.wr_index] <= tlb_wr.wr_vpn;
            ppn_q[tlb_wr.wr_index] <= tlb_wr.wr_ppn;
        end
    end

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            out_valid_q <= 1'b0;
        end else if (take) begin
            out_valid_q <= 1'b1;
        end else if (phys_out.ready) begin
            out_valid_q <= 1'b0;
        end
    end

    always_ff @(posedge aclk) begin
        if (take) begin
            // Miss keeps the virtual address
            if (hit) begin
                addr_q <= {ppn_q[in_idx], virt_in.addr[dma_req_pkg::page_off_bits-1:0]};
            end else begin
                addr_q <= virt_in.addr;
            end
            fault_q  <= virt_in.fault || !hit;
            len_q    <= virt_in.len;
            ctl_q    <= virt_in.ctl;
            sync_q   <= virt_in.sync;
            stream_q <= virt_in.stream;
            dest_q   <= virt_in.dest;
        end
    end

    assign phys_out.valid  = out_valid_q;
    assign phys_out.addr   = addr_q;
    assign phys_out.len    = len_q;
    assign phys_out.ctl    = ctl_q;
    assign phys_out.sync   = sync_q;
    assign phys_out.stream = stream_q;
    assign phys_out.dest   = dest_q;
    assign phys_out.fault  = fault_q;

endmodule

//--- hw/req_splitter.sv
`timescale 1ns/10ps

module req_splitter #(
    parameter int chunk_bytes = 1024
) (
    input  logic      aclk,
    input  logic      aresetn,
    req_stage_if.dst  req_in,
    req_stage_if.src  chunk_out
);
    localparam dma_req_pkg::len_t   chunk_len  = dma_req_pkg::len_t'(chunk_bytes);
    localparam dma_req_pkg::vaddr_t chunk_step = dma_req_pkg::vaddr_t'(chunk_bytes);

    typedef enum logic [1:0] {
        st_idle,
        st_parse,
        st_send
    } state_t;

    state_t              state_q;
    dma_req_pkg::vaddr_t next_addr_q;
    dma_req_pkg::len_t   rem_q;
    logic                ctl_q;
    logic                sync_q;
    logic                stream_q;
    dma_req_pkg::dest_t  dest_q;
    dma_req_pkg::vaddr_t chunk_addr_q;
    dma_req_pkg::len_t   chunk_len_q;
    logic                chunk_ctl_q;
    logic                last_q;
    logic                take;
    logic                give;

    assign take = (state_q == st_idle) && req_in.valid;
    assign give = (state_q == st_send) && chunk_out.ready;

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            state_q <= st_idle;
        end else begin
            case (state_q)
                st_idle: begin
                    if (take) begin
                        state_q <= st_parse;
                    end
                end
                st_parse: state_q <= st_send;
                st_send: begin
                    if (give) begin
                        state_q <= last_q ? st_idle : st_parse;
                    end
                end
                default: state_q <= st_idle;
            endcase
        end
    end

    always_ff @(posedge aclk) begin
        if (take) begin
            next_addr_q <= req_in.addr;
            rem_q       <= req_in.len;
            ctl_q       <= req_in.ctl;
            sync_q      <= req_in.sync;
            stream_q    <= req_in.stream;
            dest_q      <= req_in.dest;
        end else if (state_q == st_parse) begin
            chunk_addr_q <= next_addr_q;
            if (rem_q > chunk_len) begin
                chunk_len_q <= chunk_len;
                chunk_ctl_q <= 1'b0;
                last_q      <= 1'b0;
                rem_q       <= rem_q - chunk_len;
                next_addr_q <= next_addr_q + chunk_step;
            end else begin
                // Remainder, also covers a zero-length request
                chunk_len_q <= rem_q;
                chunk_ctl_q <= ctl_q;
                last_q      <= 1'b1;
                rem_q       <= '0;
            end
        end
    end

    assign req_in.ready = (state_q == st_idle);

    assign chunk_out.valid  = (state_q == st_send);
    assign chunk_out.addr   = chunk_addr_q;
    assign chunk_out.len    = chunk_len_q;
    assign chunk_out.ctl    = chunk_ctl_q;
    assign chunk_out.sync   = sync_q;
    assign chunk_out.stream = stream_q;
    assign chunk_out.dest   = dest_q;
    assign chunk_out.fault  = 1'b0;

endmodule

//--- hw/req_intake.sv
`timescale 1ns/10ps

module req_intake #(
    parameter int tlb_entries = 8
) (
    input  logic                  aclk,
    input  logic                  aresetn,
    input  logic                  host_cyc,
    input  logic                  host_stb,
    input  logic                  host_we,
    input  dma_req_pkg::wb_adr_t  host_adr,
    input  dma_req_pkg::wb_data_t host_dat_w,
    output dma_req_pkg::wb_data_t host_dat_r,
    output logic                  host_ack,
    req_stage_if.src              req_out,
    tlb_wr_if.src                 tlb_wr
);
    localparam int idx_bits = $clog2(tlb_entries);

    dma_req_pkg::vaddr_t   vaddr_q;
    dma_req_pkg::len_t     len_q;
    logic                  ctl_q;
    logic                  sync_q;
    logic                  stream_q;
    dma_req_pkg::dest_t    dest_q;
    dma_req_pkg::vpn_t     vpn_q;
    logic                  ack_q;
    logic                  req_valid_q;
    dma_req_pkg::wb_data_t flags_word;
    dma_req_pkg::wb_adr_t  tlb_off;
    logic                  start;
    logic                  wr_cyc;
    logic                  rd_cyc;
    logic                  ring;
    logic                  in_tlb_window;

    // New cycle only once the previous one has been acked
    assign start  = host_cyc && host_stb && !host_ack && !req_valid_q;
    assign wr_cyc = start && host_we;
    assign rd_cyc = start && !host_we;
    assign ring   = wr_cyc && (host_adr == dma_req_pkg::reg_doorbell);

    assign tlb_off       = host_adr - dma_req_pkg::tlb_base;
    assign in_tlb_window = (host_adr >= dma_req_pkg::tlb_base) && (int'(tlb_off) < tlb_entries);

    always_comb begin
        flags_word = '0;
        flags_word[dma_req_pkg::flag_ctl_bit]    = ctl_q;
        flags_word[dma_req_pkg::flag_sync_bit]   = sync_q;
        flags_word[dma_req_pkg::flag_stream_bit] = stream_q;
        flags_word[dma_req_pkg::flag_dest_lsb +: dma_req_pkg::dest_bits] = dest_q;
    end

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            vaddr_q  <= '0;
            len_q    <= '0;
            ctl_q    <= 1'b0;
            sync_q   <= 1'b0;
            stream_q <= 1'b0;
            dest_q   <= '0;
            vpn_q    <= '0;
        end else if (wr_cyc) begin
            case (host_adr)
                dma_req_pkg::reg_vaddr: vaddr_q <= host_dat_w;
                dma_req_pkg::reg_len:   len_q   <= host_dat_w[dma_req_pkg::len_bits-1:0];
                dma_req_pkg::reg_flags: begin
                    ctl_q    <= host_dat_w[dma_req_pkg::flag_ctl_bit];
                    sync_q   <= host_dat_w[dma_req_pkg::flag_sync_bit];
                    stream_q <= host_dat_w[dma_req_pkg::flag_stream_bit];
                    dest_q   <= host_dat_w[dma_req_pkg::flag_dest_lsb +: dma_req_pkg::dest_bits];
                end
                dma_req_pkg::reg_tlb_vpn: vpn_q <= host_dat_w[dma_req_pkg::pn_bits-1:0];
                default: ;
            endcase
        end
    end

    // Doorbell ack waits for the splitter
    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            ack_q       <= 1'b0;
            req_valid_q <= 1'b0;
        end else begin
            ack_q <= start && !ring;
            if (ring) begin
                req_valid_q <= 1'b1;
            end else if (req_valid_q && req_out.ready) begin
                req_valid_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (rd_cyc) begin
            case (host_adr)
                dma_req_pkg::reg_vaddr: host_dat_r <= vaddr_q;
                dma_req_pkg::reg_len:   host_dat_r <= dma_req_pkg::wb_data_t'(len_q);
                dma_req_pkg::reg_flags: host_dat_r <= flags_word;
                default:                host_dat_r <= '0;
            endcase
        end
    end

    assign host_ack = ack_q || (req_valid_q && req_out.ready);

    assign req_out.valid  = req_valid_q;
    assign req_out.addr   = vaddr_q;
    assign req_out.len    = len_q;
    assign req_out.ctl    = ctl_q;
    assign req_out.sync   = sync_q;
    assign req_out.stream = stream_q;
    assign req_out.dest   = dest_q;
    assign req_out.fault  = 1'b0;

    // Tag comes from the staging register
    assign tlb_wr.wr_en    = wr_cyc && in_tlb_window;
    assign tlb_wr.wr_index = tlb_off[idx_bits-1:0];
    assign tlb_wr.wr_vpn   = vpn_q;
    assign tlb_wr.wr_ppn   = host_dat_w[dma_req_pkg::pn_bits-1:0];
    assign tlb_wr.wr_valid = host_dat_w[dma_req_pkg::tlb_valid_bit];

endmodule

//--- hw/dma_req_if.sv
`timescale 1ns/10ps

interface req_stage_if #(
    parameter type addr_t = dma_req_pkg::vaddr_t
);
    logic               valid;
    logic               ready;
    addr_t              addr;
    dma_req_pkg::len_t  len;
    logic               ctl;
    logic               sync;
    logic               stream;
    dma_req_pkg::dest_t dest;
    logic               fault;

    modport src (
        output valid,
        output addr,
        output len,
        output ctl,
        output sync,
        output stream,
        output dest,
        output fault,
        input  ready
    );

    modport dst (
        input  valid,
        input  addr,
        input  len,
        input  ctl,
        input  sync,
        input  stream,
        input  dest,
        input  fault,
        output ready
    );
endinterface

interface tlb_wr_if #(
    parameter int tlb_entries = 8
);
    localparam int idx_bits = $clog2(tlb_entries);

    logic                wr_en;
    logic [idx_bits-1:0] wr_index;
    dma_req_pkg::vpn_t   wr_vpn;
    dma_req_pkg::ppn_t   wr_ppn;
    logic                wr_valid;

    modport src (output wr_en, output wr_index, output wr_vpn, output wr_ppn, output wr_valid);
    modport dst (input wr_en, input wr_index, input wr_vpn, input wr_ppn, input wr_valid);
endinterface

//--- hw/dma_req_pkg.sv
package dma_req_pkg;

    localparam int addr_bits     = 32;
    localparam int len_bits      = 16;
    localparam int dest_bits     = 4;
    localparam int page_off_bits = 12;
    localparam int pn_bits       = addr_bits - page_off_bits;
    localparam int wb_data_bits  = 32;
    localparam int wb_adr_bits   = 6;

    typedef logic [addr_bits-1:0]    vaddr_t;
    typedef logic [addr_bits-1:0]    paddr_t;
    typedef logic [len_bits-1:0]     len_t;
    typedef logic [dest_bits-1:0]    dest_t;
    typedef logic [pn_bits-1:0]      vpn_t;
    typedef logic [pn_bits-1:0]      ppn_t;
    typedef logic [wb_data_bits-1:0] wb_data_t;
    typedef logic [wb_adr_bits-1:0]  wb_adr_t;

    // Host word addresses
    localparam wb_adr_t reg_vaddr    = 6'd0;
    localparam wb_adr_t reg_len      = 6'd1;
    localparam wb_adr_t reg_flags    = 6'd2;
    localparam wb_adr_t reg_doorbell = 6'd3;
    localparam wb_adr_t reg_tlb_vpn  = 6'd4;
    localparam wb_adr_t tlb_base     = 6'd32;

    // Flags word
    localparam int flag_ctl_bit    = 0;
    localparam int flag_sync_bit   = 1;
    localparam int flag_stream_bit = 2;
    localparam int flag_dest_lsb   = 4;

    // TLB entry word, ppn sits in the low pn_bits
    localparam int tlb_valid_bit = 31;

    // Command word on cmd_dat
    localparam int cmd_len_lsb    = 0;
    localparam int cmd_dest_lsb   = 16;
    localparam int cmd_ctl_bit    = 20;
    localparam int cmd_sync_bit   = 21;
    localparam int cmd_stream_bit = 22;
    localparam int cmd_fault_bit  = 23;

endpackage
